// ==== verilog/bf16_pkg.sv ====
package bf16_pkg;

	// bfloat16 word layout
	// sign on top, then biased exponent, then stored mantissa
	localparam int WIDTH = 16;
	localparam int EXP_WIDTH = 8;
	localparam int MAN_WIDTH = 7;
	localparam int SIGN_POS = 15;

	// exponent field 127 means 2^0
	localparam int EXP_BIAS = 127;

	// command codes seen on oper
	localparam int OP_WIDTH = 3;

	// add and sub share the add unit
	localparam logic [OP_WIDTH-1:0] OP_ADD = 3'd0;
	localparam logic [OP_WIDTH-1:0] OP_SUB = 3'd1;

	// compare, result is ONE or zero
	localparam logic [OP_WIDTH-1:0] OP_SLT = 3'd2;

	localparam logic [OP_WIDTH-1:0] OP_MUL = 3'd3;
	localparam logic [OP_WIDTH-1:0] OP_DIV = 3'd4;

	// codes 5 to 7 start nothing

	// saturation magnitude, exponent 254 with all mantissa bits set
	// the sign is supplied by the unit
	localparam logic [WIDTH-1:0] MAX_FINITE = 16'h7F7F;

	// 1.0, the true result of set-less-than
	localparam logic [WIDTH-1:0] ONE = 16'h3F80;

endpackage

// ==== verilog/bf16_slt.sv ====
`timescale 1ns/10ps

module bf16_slt
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [bf16_pkg::WIDTH-1:0] a,
	input logic [bf16_pkg::WIDTH-1:0] b,
	output logic can_accept_cmd,
	output logic data_valid,
	output logic [bf16_pkg::WIDTH-1:0] data
);

	logic a_zero;
	logic b_zero;
	logic a_neg;
	logic b_neg;
	logic [bf16_pkg::SIGN_POS-1:0] a_mag;
	logic [bf16_pkg::SIGN_POS-1:0] b_mag;
	logic less;

	// exponent field 0 reads as zero of either sign
	assign a_zero = (a[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH] == '0);
	assign b_zero = (b[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH] == '0);

	// zeros lose their sign so +0 and -0 compare equal
	assign a_neg = a[bf16_pkg::SIGN_POS] & ~a_zero;
	assign b_neg = b[bf16_pkg::SIGN_POS] & ~b_zero;
	assign a_mag = a_zero ? '0 : a[bf16_pkg::SIGN_POS-1:0];
	assign b_mag = b_zero ? '0 : b[bf16_pkg::SIGN_POS-1:0];

	// sign-magnitude ordering
	always_comb
	begin
		if (a_neg != b_neg)
		begin
			// negative against positive
			less = a_neg;
		end
		else if (a_neg)
		begin
			// both negative, larger magnitude is smaller
			less = (a_mag > b_mag);
		end
		else
		begin
			less = (a_mag < b_mag);
		end
	end

	// single cycle, never busy
	assign can_accept_cmd = 1'b1;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			data_valid <= 1'b0;
		end
		else
		begin
			data_valid <= start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			data <= less ? bf16_pkg::ONE : '0;
		end
	end

endmodule

// ==== verilog/bf16_add.sv ====
`timescale 1ns/10ps

module bf16_add
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [bf16_pkg::WIDTH-1:0] a,
	input logic [bf16_pkg::WIDTH-1:0] b,
	output logic can_accept_cmd,
	output logic data_valid,
	output logic [bf16_pkg::WIDTH-1:0] data
);

	// hidden bit plus stored bits
	localparam int SIG_W = bf16_pkg::MAN_WIDTH + 1;
	// aligned width with guard, round and sticky below
	localparam int AL_W = SIG_W + 3;
	// exponent with room to go negative or past 255
	localparam int EW = bf16_pkg::EXP_WIDTH + 2;

	logic accept;
	logic busy;

	logic a_ge_b;
	logic [bf16_pkg::WIDTH-1:0] big;
	logic [bf16_pkg::WIDTH-1:0] sml;
	logic [bf16_pkg::EXP_WIDTH-1:0] big_exp;
	logic [bf16_pkg::EXP_WIDTH-1:0] sml_exp;
	logic [SIG_W-1:0] big_sig;
	logic [SIG_W-1:0] sml_sig;
	logic [bf16_pkg::EXP_WIDTH-1:0] exp_diff;
	logic [3:0] shamt;
	logic [2*AL_W-1:0] shifted;
	logic [AL_W-1:0] sml_al;

	logic s1_valid;
	logic s1_sign;
	logic s1_sub;
	logic [bf16_pkg::EXP_WIDTH-1:0] s1_exp;
	logic [SIG_W-1:0] s1_big_sig;
	logic [AL_W-1:0] s1_sml_al;

	logic s2_valid;
	logic s2_sign;
	logic [bf16_pkg::EXP_WIDTH-1:0] s2_exp;
	logic [AL_W:0] s2_sum;

	logic [3:0] lz;
	logic [AL_W-1:0] norm;
	logic [bf16_pkg::MAN_WIDTH-1:0] res_man;
	logic signed [EW-1:0] res_exp;
	logic [bf16_pkg::WIDTH-1:0] result;

	assign can_accept_cmd = ~busy;
	assign accept = start & can_accept_cmd;

	// stage 1, order by magnitude so the difference never goes negative
	assign a_ge_b = (a[bf16_pkg::SIGN_POS-1:0] >= b[bf16_pkg::SIGN_POS-1:0]);
	assign big = a_ge_b ? a : b;
	assign sml = a_ge_b ? b : a;
	assign big_exp = big[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];
	assign sml_exp = sml[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];

	// exponent 0 is a zero, no hidden bit
	assign big_sig = (big_exp != '0) ? {1'b1, big[bf16_pkg::MAN_WIDTH-1:0]} : '0;
	assign sml_sig = (sml_exp != '0) ? {1'b1, sml[bf16_pkg::MAN_WIDTH-1:0]} : '0;

	// anything past the sticky position behaves the same
	assign exp_diff = big_exp - sml_exp;
	assign shamt = (exp_diff > 8'(AL_W)) ? 4'(AL_W) : exp_diff[3:0];

	assign shifted = {sml_sig, {(2*AL_W-SIG_W){1'b0}}} >> shamt;
	// shifted-out bits collapse into sticky
	assign sml_al = {shifted[2*AL_W-1:AL_W+1], shifted[AL_W] | (|shifted[AL_W-1:0])};

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_sign <= big[bf16_pkg::SIGN_POS];
			s1_sub <= a[bf16_pkg::SIGN_POS] ^ b[bf16_pkg::SIGN_POS];
			s1_exp <= big_exp;
			s1_big_sig <= big_sig;
			s1_sml_al <= sml_al;
		end
	end

	// stage 2, add or subtract magnitudes
	always_ff @(posedge clk)
	begin
		s2_sign <= s1_sign;
		s2_exp <= s1_exp;
		if (s1_sub)
		begin
			s2_sum <= {1'b0, s1_big_sig, 3'b000} - {1'b0, s1_sml_al};
		end
		else
		begin
			s2_sum <= {1'b0, s1_big_sig, 3'b000} + {1'b0, s1_sml_al};
		end
	end

	// stage 3, leading one search, last hit is the highest set bit
	always_comb
	begin
		lz = '0;
		for (int i = 0; i < AL_W; i++)
		begin
			if (s2_sum[i])
			begin
				lz = 4'(AL_W - 1 - i);
			end
		end
	end

	assign norm = s2_sum[AL_W-1:0] << lz;

	always_comb
	begin
		if (s2_sum[AL_W])
		begin
			// carry out, one step right
			res_man = s2_sum[AL_W-1 -: bf16_pkg::MAN_WIDTH];
			res_exp = EW'($signed({2'b00, s2_exp}) + 1);
		end
		else
		begin
			res_man = norm[AL_W-2 -: bf16_pkg::MAN_WIDTH];
			res_exp = $signed({2'b00, s2_exp}) - $signed({{(EW-4){1'b0}}, lz});
		end
	end

	always_comb
	begin
		if ((s2_sum == '0) || (res_exp <= 0))
		begin
			// cancellation or underflow, always +0
			result = '0;
		end
		else if (res_exp[bf16_pkg::EXP_WIDTH])
		begin
			result = {s2_sign, bf16_pkg::MAX_FINITE[bf16_pkg::SIGN_POS-1:0]};
		end
		else
		begin
			result = {s2_sign, res_exp[bf16_pkg::EXP_WIDTH-1:0], res_man};
		end
	end

	always_ff @(posedge clk)
	begin
		if (s2_valid)
		begin
			data <= result;
		end
	end

	// pipeline valids and busy
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			data_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= accept;
			s2_valid <= s1_valid;
			data_valid <= s2_valid;
			if (accept)
			begin
				busy <= 1'b1;
			end
			else if (s2_valid)
			begin
				// free again in the result cycle
				busy <= 1'b0;
			end
		end
	end

	a_busy_no_result: assert property (@(posedge clk) disable iff (rst)
		(start && busy) |-> !data_valid)
		else $error("add result while busy with a pending start");

endmodule

// ==== verilog/bf16_mul.sv ====
`timescale 1ns/10ps

module bf16_mul
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [bf16_pkg::WIDTH-1:0] a,
	input logic [bf16_pkg::WIDTH-1:0] b,
	output logic can_accept_cmd,
	output logic data_valid,
	output logic [bf16_pkg::WIDTH-1:0] data
);

	localparam int SIG_W = bf16_pkg::MAN_WIDTH + 1;
	// signed exponent, covers -127 up to 384
	localparam int EW = bf16_pkg::EXP_WIDTH + 2;

	logic accept;
	logic [bf16_pkg::EXP_WIDTH-1:0] a_exp;
	logic [bf16_pkg::EXP_WIDTH-1:0] b_exp;
	logic [SIG_W-1:0] a_sig;
	logic [SIG_W-1:0] b_sig;

	logic s1_valid;
	logic s1_sign;
	logic s1_zero;
	logic signed [EW-1:0] s1_exp;
	logic [2*SIG_W-1:0] s1_prod;

	logic [bf16_pkg::MAN_WIDTH-1:0] res_man;
	logic signed [EW-1:0] res_exp;
	logic [bf16_pkg::WIDTH-1:0] result;

	// busy only while stage 1 holds a command
	assign can_accept_cmd = ~s1_valid;
	assign accept = start & can_accept_cmd;

	assign a_exp = a[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];
	assign b_exp = b[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];
	assign a_sig = {1'b1, a[bf16_pkg::MAN_WIDTH-1:0]};
	assign b_sig = {1'b1, b[bf16_pkg::MAN_WIDTH-1:0]};

	// stage 1, full 8x8 product and unbiased exponent sum
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_sign <= a[bf16_pkg::SIGN_POS] ^ b[bf16_pkg::SIGN_POS];
			s1_zero <= (a_exp == '0) || (b_exp == '0);
			s1_exp <= EW'($signed({2'b00, a_exp}) + $signed({2'b00, b_exp})
				- bf16_pkg::EXP_BIAS);
			s1_prod <= a_sig * b_sig;
		end
	end

	// stage 2, product is in [1,4), at most one bit of normalization
	always_comb
	begin
		if (s1_prod[2*SIG_W-1])
		begin
			res_man = s1_prod[2*SIG_W-2 -: bf16_pkg::MAN_WIDTH];
			res_exp = EW'(s1_exp + 1);
		end
		else
		begin
			res_man = s1_prod[2*SIG_W-3 -: bf16_pkg::MAN_WIDTH];
			res_exp = s1_exp;
		end
	end

	always_comb
	begin
		if (s1_zero || (res_exp <= 0))
		begin
			// zero operand or underflow keeps the xor sign
			result = {s1_sign, {(bf16_pkg::WIDTH-1){1'b0}}};
		end
		else if (res_exp[bf16_pkg::EXP_WIDTH])
		begin
			result = {s1_sign, bf16_pkg::MAX_FINITE[bf16_pkg::SIGN_POS-1:0]};
		end
		else
		begin
			result = {s1_sign, res_exp[bf16_pkg::EXP_WIDTH-1:0], res_man};
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			data <= result;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			data_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= accept;
			data_valid <= s1_valid;
		end
	end

	a_two_cycles: assert property (@(posedge clk) disable iff (rst)
		(start && can_accept_cmd) |-> ##2 data_valid)
		else $error("multiply result not two cycles after start");

endmodule

// ==== verilog/bf16_div.sv ====
`timescale 1ns/10ps

module bf16_div
#(
	parameter int DIV_STEPS = 10
)
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [bf16_pkg::WIDTH-1:0] a,
	input logic [bf16_pkg::WIDTH-1:0] b,
	output logic can_accept_cmd,
	output logic data_valid,
	output logic [bf16_pkg::WIDTH-1:0] data
);

	localparam int SIG_W = bf16_pkg::MAN_WIDTH + 1;
	localparam int EW = bf16_pkg::EXP_WIDTH + 2;
	localparam int CNT_W = $clog2(DIV_STEPS + 1);

	logic accept;
	logic busy;
	logic last;
	logic [CNT_W-1:0] cnt;
	logic [bf16_pkg::EXP_WIDTH-1:0] a_exp;
	logic [bf16_pkg::EXP_WIDTH-1:0] b_exp;

	// partial remainder needs one bit above the divisor
	logic [SIG_W:0] rem;
	logic [SIG_W-1:0] dsr;
	logic [DIV_STEPS-1:0] quo;
	logic signed [EW-1:0] exp_q;
	logic sign_q;
	logic num_zero;
	logic den_zero;

	logic fits;
	logic [SIG_W:0] diff;
	logic [DIV_STEPS:0] quo_st;
	logic [bf16_pkg::MAN_WIDTH-1:0] res_man;
	logic signed [EW-1:0] res_exp;
	logic [bf16_pkg::WIDTH-1:0] result;

	assign can_accept_cmd = ~busy;
	assign accept = start & can_accept_cmd;
	// all quotient bits are in, normalize this cycle
	assign last = busy && (cnt == CNT_W'(DIV_STEPS));

	assign a_exp = a[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];
	assign b_exp = b[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];

	// one restoring step
	assign fits = (rem >= {1'b0, dsr});
	assign diff = rem - {1'b0, dsr};

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			// setup, quotient first bit has weight 2^0
			rem <= {1'b0, (a_exp != '0), a[bf16_pkg::MAN_WIDTH-1:0]};
			dsr <= {(b_exp != '0), b[bf16_pkg::MAN_WIDTH-1:0]};
			quo <= '0;
			exp_q <= EW'($signed({2'b00, a_exp}) - $signed({2'b00, b_exp})
				+ bf16_pkg::EXP_BIAS);
			sign_q <= a[bf16_pkg::SIGN_POS] ^ b[bf16_pkg::SIGN_POS];
			num_zero <= (a_exp == '0);
			den_zero <= (b_exp == '0);
		end
		else if (busy && !last)
		begin
			quo <= {quo[DIV_STEPS-2:0], fits};
			// leftover remainder is below the divisor, top bit free for the shift
			rem <= {(fits ? diff[SIG_W-1:0] : rem[SIG_W-1:0]), 1'b0};
		end
	end

	// sticky sits below the truncation point
	assign quo_st = {quo, (rem != '0)};

	// quotient is in (0.5, 2)
	always_comb
	begin
		if (quo[DIV_STEPS-1])
		begin
			res_man = quo_st[DIV_STEPS-1 -: bf16_pkg::MAN_WIDTH];
			res_exp = exp_q;
		end
		else
		begin
			res_man = quo_st[DIV_STEPS-2 -: bf16_pkg::MAN_WIDTH];
			res_exp = EW'(exp_q - 1);
		end
	end

	always_comb
	begin
		if (den_zero)
		begin
			// divide by zero saturates, also for 0/0
			result = {sign_q, bf16_pkg::MAX_FINITE[bf16_pkg::SIGN_POS-1:0]};
		end
		else if (num_zero || (res_exp <= 0))
		begin
			result = {sign_q, {(bf16_pkg::WIDTH-1){1'b0}}};
		end
		else if (res_exp[bf16_pkg::EXP_WIDTH])
		begin
			result = {sign_q, bf16_pkg::MAX_FINITE[bf16_pkg::SIGN_POS-1:0]};
		end
		else
		begin
			result = {sign_q, res_exp[bf16_pkg::EXP_WIDTH-1:0], res_man};
		end
	end

	always_ff @(posedge clk)
	begin
		if (last)
		begin
			data <= result;
		end
	end

	// step counter and busy flag
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			data_valid <= 1'b0;
		end
		else
		begin
			data_valid <= last;
			if (accept)
			begin
				busy <= 1'b1;
				cnt <= '0;
			end
			else if (last)
			begin
				busy <= 1'b0;
			end
			else if (busy)
			begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (rst)
		cnt <= CNT_W'(DIV_STEPS))
		else $error("divider step counter past DIV_STEPS");

endmodule

// ==== verilog/bf16_fpu.sv ====
`timescale 1ns/10ps

module bf16_fpu
#(
	parameter int DIV_STEPS = 10
)
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [bf16_pkg::OP_WIDTH-1:0] oper,
	input logic [bf16_pkg::WIDTH-1:0] a,
	input logic [bf16_pkg::WIDTH-1:0] b,
	output logic can_accept_cmd,
	output logic data_valid,
	output logic [bf16_pkg::WIDTH-1:0] data
);

	logic accept;
	logic add_start;
	logic slt_start;
	logic mul_start;
	logic div_start;
	logic [bf16_pkg::WIDTH-1:0] add_b;
	logic [bf16_pkg::OP_WIDTH-1:0] oper_q;

	logic add_can_accept;
	logic slt_can_accept;
	logic mul_can_accept;
	logic div_can_accept;
	logic add_valid;
	logic slt_valid;
	logic mul_valid;
	logic div_valid;
	logic [bf16_pkg::WIDTH-1:0] add_data;
	logic [bf16_pkg::WIDTH-1:0] slt_data;
	logic [bf16_pkg::WIDTH-1:0] mul_data;
	logic [bf16_pkg::WIDTH-1:0] div_data;
	logic [bf16_pkg::WIDTH-1:0] sel_data;

	// one command in flight, so idle means every unit idle
	assign can_accept_cmd = add_can_accept & slt_can_accept & mul_can_accept & div_can_accept;
	assign accept = start & can_accept_cmd;

	// reserved codes match nothing and start no unit
	assign add_start = accept && ((oper == bf16_pkg::OP_ADD) || (oper == bf16_pkg::OP_SUB));
	assign slt_start = accept && (oper == bf16_pkg::OP_SLT);
	assign mul_start = accept && (oper == bf16_pkg::OP_MUL);
	assign div_start = accept && (oper == bf16_pkg::OP_DIV);

	// subtract is add with b negated
	assign add_b = (oper == bf16_pkg::OP_SUB) ?
		{~b[bf16_pkg::SIGN_POS], b[bf16_pkg::SIGN_POS-1:0]} : b;

	bf16_add u_add (.clk(clk), .rst(rst), .start(add_start), .a(a), .b(add_b),
		.can_accept_cmd(add_can_accept), .data_valid(add_valid), .data(add_data));

	bf16_slt u_slt (.clk(clk), .rst(rst), .start(slt_start), .a(a), .b(b),
		.can_accept_cmd(slt_can_accept), .data_valid(slt_valid), .data(slt_data));

	bf16_mul u_mul (.clk(clk), .rst(rst), .start(mul_start), .a(a), .b(b),
		.can_accept_cmd(mul_can_accept), .data_valid(mul_valid), .data(mul_data));

	bf16_div #(.DIV_STEPS(DIV_STEPS)) u_div (.clk(clk), .rst(rst), .start(div_start),
		.a(a), .b(b), .can_accept_cmd(div_can_accept), .data_valid(div_valid),
		.data(div_data));

	// remember which unit owes the result
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			oper_q <= bf16_pkg::OP_ADD;
		end
		else if (add_start || slt_start || mul_start || div_start)
		begin
			oper_q <= oper;
		end
	end

	always_comb
	begin
		case (oper_q)
		bf16_pkg::OP_ADD, bf16_pkg::OP_SUB:
		begin
			data_valid = add_valid;
			sel_data = add_data;
		end
		bf16_pkg::OP_SLT:
		begin
			data_valid = slt_valid;
			sel_data = slt_data;
		end
		bf16_pkg::OP_MUL:
		begin
			data_valid = mul_valid;
			sel_data = mul_data;
		end
		bf16_pkg::OP_DIV:
		begin
			data_valid = div_valid;
			sel_data = div_data;
		end
		default:
		begin
			data_valid = 1'b0;
			sel_data = '0;
		end
		endcase
	end

	// data reads zero outside the result pulse
	assign data = data_valid ? sel_data : '0;

	a_one_start: assert property (@(posedge clk) disable iff (rst)
		$onehot0({add_start, slt_start, mul_start, div_start}))
		else $error("more than one unit started");

endmodule

// ==== tb/tb_bf16_fpu.sv ====
`timescale 1ns/10ps

module tb_bf16_fpu;

	// dut runs with its default divider length
	localparam int DIV_STEPS = 10;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RANDOM = 200;
	localparam int N_DIV = 100;
	// every command issued, rounded up, sizes the watchdog
	localparam int N_CMDS = 2 * N_RANDOM + N_DIV + 60;
	localparam int CMD_LIMIT = 40;

	logic clk;
	logic rst;
	logic start;
	logic [bf16_pkg::OP_WIDTH-1:0] oper;
	logic [bf16_pkg::WIDTH-1:0] a;
	logic [bf16_pkg::WIDTH-1:0] b;
	logic can_accept_cmd;
	logic data_valid;
	logic [bf16_pkg::WIDTH-1:0] data;

	logic [31:0] lcg_state;
	int n_checks;
	int n_errors;
	int test_checks;
	int test_errors;
	// result and latency of the last command
	logic [bf16_pkg::WIDTH-1:0] last_data;
	int last_latency;

	bf16_fpu dut (.clk(clk), .rst(rst), .start(start), .oper(oper), .a(a), .b(b),
		.can_accept_cmd(can_accept_cmd), .data_valid(data_valid), .data(data));

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// hard stop, about 20 cycles per command plus reset and slack
	initial
	begin
		#((N_CMDS * 20 + RESET_CYCLES + 200) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	// inputs change 1 ns after the edge, outputs are settled by then
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper lcg bits only, the low ones repeat quickly
	function automatic logic [bf16_pkg::WIDTH-1:0] random_operand(int exp_lo, int exp_span);
		logic [31:0] r;
		int e;
		r = next_random();
		e = exp_lo + int'(r[23:16] % exp_span);
		return {r[31], e[7:0], r[30:24]};
	endfunction

	function automatic int exp_of(logic [bf16_pkg::WIDTH-1:0] x);
		return x[bf16_pkg::SIGN_POS-1 -: bf16_pkg::EXP_WIDTH];
	endfunction

	// significand with hidden bit, 1.0 reads as 128
	function automatic int sig_of(logic [bf16_pkg::WIDTH-1:0] x);
		return {1'b1, x[bf16_pkg::MAN_WIDTH-1:0]};
	endfunction

	function automatic int msb_index(longint unsigned v);
		int idx;
		idx = 0;
		for (int i = 0; i < 64; i++)
		begin
			if (v[i])
				idx = i;
		end
		return idx;
	endfunction

	// the 7 bits just below the leading one, the rest is cut off
	function automatic int stored_bits(longint unsigned v, int p);
		longint unsigned t;
		if (p >= 7)
			t = v >> (p - 7);
		else
			t = v << (7 - p);
		return int'(t & 64'h7F);
	endfunction

	// flush below the smallest normal, saturate past exponent 255
	function automatic logic [bf16_pkg::WIDTH-1:0] pack_result(logic sign, int exp, int man,
		logic zero_sign);
		if (exp <= 0)
			return {zero_sign, 15'h0};
		if (exp > 255)
			return {sign, bf16_pkg::MAX_FINITE[bf16_pkg::SIGN_POS-1:0]};
		return {sign, exp[7:0], man[6:0]};
	endfunction

	// exact sum at the scale of the smaller exponent
	function automatic logic [bf16_pkg::WIDTH-1:0] sum_model(logic [bf16_pkg::WIDTH-1:0] x,
		logic [bf16_pkg::WIDTH-1:0] y);
		int ex;
		int ey;
		int e_lo;
		int p;
		longint vx;
		longint vy;
		longint s;
		longint unsigned mag;
		ex = exp_of(x);
		ey = exp_of(y);
		if (ex == 0 && ey == 0)
			return '0;
		if (ex == 0)
			e_lo = ey;
		else if (ey == 0 || ey < ex)
			e_lo = (ey == 0) ? ex : ey;
		else
			e_lo = ex;
		vx = (ex == 0) ? 0 : longint'(sig_of(x)) << (ex - e_lo);
		vy = (ey == 0) ? 0 : longint'(sig_of(y)) << (ey - e_lo);
		if (x[bf16_pkg::SIGN_POS])
			vx = -vx;
		if (y[bf16_pkg::SIGN_POS])
			vy = -vy;
		s = vx + vy;
		// cancellation gives +0
		if (s == 0)
			return '0;
		mag = (s < 0) ? -s : s;
		p = msb_index(mag);
		// mag of 128 at e_lo is the value of exponent e_lo
		return pack_result(s < 0, e_lo + p - 7, stored_bits(mag, p), 1'b0);
	endfunction

	function automatic logic [bf16_pkg::WIDTH-1:0] product_model(logic [bf16_pkg::WIDTH-1:0] x,
		logic [bf16_pkg::WIDTH-1:0] y);
		logic sign;
		longint unsigned prod;
		int p;
		sign = x[bf16_pkg::SIGN_POS] ^ y[bf16_pkg::SIGN_POS];
		if (exp_of(x) == 0 || exp_of(y) == 0)
			return {sign, 15'h0};
		prod = sig_of(x) * sig_of(y);
		p = msb_index(prod);
		// 1.0 times 1.0 lands on bit 14
		return pack_result(sign, exp_of(x) + exp_of(y) - bf16_pkg::EXP_BIAS + p - 14,
			stored_bits(prod, p), sign);
	endfunction

	function automatic logic [bf16_pkg::WIDTH-1:0] quotient_model(logic [bf16_pkg::WIDTH-1:0] x,
		logic [bf16_pkg::WIDTH-1:0] y);
		logic sign;
		longint unsigned q;
		int p;
		sign = x[bf16_pkg::SIGN_POS] ^ y[bf16_pkg::SIGN_POS];
		if (exp_of(y) == 0)
			return {sign, bf16_pkg::MAX_FINITE[bf16_pkg::SIGN_POS-1:0]};
		if (exp_of(x) == 0)
			return {sign, 15'h0};
		// integer division already truncates, ratio 1.0 is bit 16
		q = (longint'(sig_of(x)) << 16) / sig_of(y);
		p = msb_index(q);
		return pack_result(sign, exp_of(x) - exp_of(y) + bf16_pkg::EXP_BIAS + p - 16,
			stored_bits(q, p), sign);
	endfunction

	// signed key, zeros of both signs map to 0
	function automatic logic [bf16_pkg::WIDTH-1:0] less_model(logic [bf16_pkg::WIDTH-1:0] x,
		logic [bf16_pkg::WIDTH-1:0] y);
		int kx;
		int ky;
		kx = (exp_of(x) == 0) ? 0 : int'(x[bf16_pkg::SIGN_POS-1:0]);
		ky = (exp_of(y) == 0) ? 0 : int'(y[bf16_pkg::SIGN_POS-1:0]);
		if (x[bf16_pkg::SIGN_POS])
			kx = -kx;
		if (y[bf16_pkg::SIGN_POS])
			ky = -ky;
		return (kx < ky) ? bf16_pkg::ONE : '0;
	endfunction

	task automatic compare_word(string name, logic [bf16_pkg::WIDTH-1:0] got,
		logic [bf16_pkg::WIDTH-1:0] expected);
		n_checks++;
		if (got !== expected)
		begin
			n_errors++;
			$display("error %s: got 0x%04h, expected 0x%04h", name, got, expected);
		end
	endtask

	task automatic compare_flag(string name, logic got, logic expected);
		n_checks++;
		if (got !== expected)
		begin
			n_errors++;
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic compare_count(string name, int got, int expected);
		n_checks++;
		if (got != expected)
		begin
			n_errors++;
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic begin_test();
		test_checks = n_checks;
		test_errors = n_errors;
	endtask

	task automatic end_test(string name);
		$display("%s: %0d checks, %0d errors", name, n_checks - test_checks,
			n_errors - test_errors);
	endtask

	// issue one command and wait for its pulse, leaves time at the pulse
	task automatic run_cmd(logic [bf16_pkg::OP_WIDTH-1:0] op, logic [bf16_pkg::WIDTH-1:0] op_a,
		logic [bf16_pkg::WIDTH-1:0] op_b, logic check_busy);
		int cycles;
		logic got_valid;
		compare_flag("can_accept_cmd", can_accept_cmd, 1'b1);
		start = 1'b1;
		oper = op;
		a = op_a;
		b = op_b;
		cycles = 0;
		got_valid = 1'b0;
		while (!got_valid && cycles < CMD_LIMIT)
		begin
			next_cycle();
			cycles++;
			if (data_valid)
				got_valid = 1'b1;
			else
			begin
				compare_word("data", data, '0);
				if (check_busy)
					compare_flag("can_accept_cmd", can_accept_cmd, 1'b0);
			end
			start = 1'b0;
		end
		last_latency = cycles;
		last_data = data;
		if (!got_valid)
		begin
			n_errors++;
			$display("no data_valid within %0d cycles for op %0d a %04h b %04h",
				CMD_LIMIT, op, op_a, op_b);
		end
	endtask

	// reset state, then results taken while a new command is accepted
	task automatic reset_tests();
		begin_test();
		compare_flag("can_accept_cmd", can_accept_cmd, 1'b1);
		compare_flag("data_valid", data_valid, 1'b0);
		compare_word("data", data, '0);
		run_cmd(bf16_pkg::OP_SLT, 16'h3F80, 16'h4000, 1'b0);
		compare_word("data", last_data, bf16_pkg::ONE);
		compare_count("slt latency", last_latency, 1);
		// next start lands on the edge right after this pulse
		run_cmd(bf16_pkg::OP_MUL, 16'h3FC0, 16'h4000, 1'b0);
		compare_word("data", last_data, 16'h4040);
		compare_count("mul latency", last_latency, 2);
		run_cmd(bf16_pkg::OP_ADD, 16'h3F80, 16'h3F80, 1'b0);
		compare_word("data", last_data, 16'h4000);
		compare_count("add latency", last_latency, 3);
		end_test("reset and back to back");
	endtask

	task automatic add_sub_tests();
		logic [bf16_pkg::WIDTH-1:0] x;
		logic [bf16_pkg::WIDTH-1:0] y;
		logic [bf16_pkg::WIDTH-1:0] y_eff;
		logic [bf16_pkg::OP_WIDTH-1:0] op;
		logic [31:0] r;
		int e;
		begin_test();
		run_cmd(bf16_pkg::OP_SUB, 16'h4040, 16'h3FC0, 1'b0);
		compare_word("data", last_data, 16'h3FC0);
		run_cmd(bf16_pkg::OP_SUB, 16'hC2AB, 16'hC2AB, 1'b0);
		compare_word("data", last_data, 16'h0000);
		// 1 + 2^-8 drops the low bit
		run_cmd(bf16_pkg::OP_ADD, 16'h3F80, 16'h3B80, 1'b0);
		compare_word("data", last_data, 16'h3F80);
		// 1 - 2^-9 truncates down to 0x3F7F
		run_cmd(bf16_pkg::OP_SUB, 16'h3F80, 16'h3B00, 1'b0);
		compare_word("data", last_data, 16'h3F7F);
		for (int i = 0; i < N_RANDOM; i++)
		begin
			x = random_operand(1, 255);
			r = next_random();
			// keep the exponents within 20 of each other
			e = exp_of(x) + int'(r[23:16] % 41) - 20;
			if (e < 1 || e > 255)
				e = exp_of(x);
			y = {r[31], e[7:0], r[30:24]};
			op = r[15] ? bf16_pkg::OP_SUB : bf16_pkg::OP_ADD;
			y_eff = r[15] ? {~y[bf16_pkg::SIGN_POS], y[bf16_pkg::SIGN_POS-1:0]} : y;
			run_cmd(op, x, y, 1'b0);
			compare_word("data", last_data, sum_model(x, y_eff));
		end
		end_test("add and subtract");
	endtask

	task automatic multiply_tests();
		logic [bf16_pkg::WIDTH-1:0] x;
		logic [bf16_pkg::WIDTH-1:0] y;
		begin_test();
		// 2^127 squared runs off the top
		run_cmd(bf16_pkg::OP_MUL, 16'h7F00, 16'h7F00, 1'b0);
		compare_word("data", last_data, 16'h7F7F);
		run_cmd(bf16_pkg::OP_MUL, 16'hFF00, 16'h7F00, 1'b0);
		compare_word("data", last_data, 16'hFF7F);
		// 2^-126 squared flushes, sign kept
		run_cmd(bf16_pkg::OP_MUL, 16'h0080, 16'h8080, 1'b0);
		compare_word("data", last_data, 16'h8000);
		compare_count("mul latency", last_latency, 2);
		for (int i = 0; i < N_RANDOM; i++)
		begin
			// mostly mid-range, every eighth pair anywhere
			x = (i % 8 == 0) ? random_operand(0, 256) : random_operand(64, 128);
			y = (i % 8 == 0) ? random_operand(0, 256) : random_operand(64, 128);
			run_cmd(bf16_pkg::OP_MUL, x, y, 1'b0);
			compare_word("data", last_data, product_model(x, y));
		end
		end_test("multiply");
	endtask

	task automatic divide_tests();
		logic [bf16_pkg::WIDTH-1:0] x;
		logic [bf16_pkg::WIDTH-1:0] y;
		begin_test();
		run_cmd(bf16_pkg::OP_DIV, 16'h4040, 16'h3FC0, 1'b1);
		compare_word("data", last_data, 16'h4000);
		compare_count("div latency", last_latency, DIV_STEPS + 2);
		// 1/3 truncated, not rounded up
		run_cmd(bf16_pkg::OP_DIV, 16'h3F80, 16'h4040, 1'b1);
		compare_word("data", last_data, 16'h3EAA);
		run_cmd(bf16_pkg::OP_DIV, 16'h4000, 16'h0000, 1'b1);
		compare_word("data", last_data, 16'h7F7F);
		run_cmd(bf16_pkg::OP_DIV, 16'h4000, 16'h8000, 1'b1);
		compare_word("data", last_data, 16'hFF7F);
		run_cmd(bf16_pkg::OP_DIV, 16'hC000, 16'h0000, 1'b1);
		compare_word("data", last_data, 16'hFF7F);
		for (int i = 0; i < N_DIV; i++)
		begin
			x = (i % 8 == 0) ? random_operand(0, 256) : random_operand(64, 128);
			y = (i % 8 == 0) ? random_operand(0, 256) : random_operand(64, 128);
			run_cmd(bf16_pkg::OP_DIV, x, y, 1'b1);
			compare_word("data", last_data, quotient_model(x, y));
			compare_count("div latency", last_latency, DIV_STEPS + 2);
		end
		end_test("divide");
	endtask

	task automatic compare_tests();
		logic [bf16_pkg::WIDTH-1:0] x;
		logic [bf16_pkg::WIDTH-1:0] y;
		begin_test();
		run_cmd(bf16_pkg::OP_SLT, 16'h3F80, 16'h4000, 1'b0);
		compare_word("data", last_data, bf16_pkg::ONE);
		run_cmd(bf16_pkg::OP_SLT, 16'h4000, 16'h3F80, 1'b0);
		compare_word("data", last_data, 16'h0000);
		run_cmd(bf16_pkg::OP_SLT, 16'hBF80, 16'h3F80, 1'b0);
		compare_word("data", last_data, bf16_pkg::ONE);
		run_cmd(bf16_pkg::OP_SLT, 16'h3F80, 16'hBF80, 1'b0);
		compare_word("data", last_data, 16'h0000);
		// larger magnitude is smaller when negative
		run_cmd(bf16_pkg::OP_SLT, 16'hC000, 16'hBF80, 1'b0);
		compare_word("data", last_data, bf16_pkg::ONE);
		run_cmd(bf16_pkg::OP_SLT, 16'h4040, 16'h4040, 1'b0);
		compare_word("data", last_data, 16'h0000);
		run_cmd(bf16_pkg::OP_SLT, 16'h8000, 16'h0000, 1'b0);
		compare_word("data", last_data, 16'h0000);
		run_cmd(bf16_pkg::OP_SLT, 16'h0000, 16'h8000, 1'b0);
		compare_word("data", last_data, 16'h0000);
		// exponent 0 with mantissa bits is still zero
		run_cmd(bf16_pkg::OP_SLT, 16'h0000, 16'h0001, 1'b0);
		compare_word("data", last_data, 16'h0000);
		for (int i = 0; i < 20; i++)
		begin
			x = random_operand(120, 16);
			y = random_operand(120, 16);
			run_cmd(bf16_pkg::OP_SLT, x, y, 1'b0);
			compare_word("data", last_data, less_model(x, y));
		end
		end_test("set less than");
	endtask

	// starts during a busy divide and reserved codes leave no trace
	task automatic ignored_cmd_tests();
		int pulses;
		int latency;
		logic [bf16_pkg::WIDTH-1:0] got;
		begin_test();
		pulses = 0;
		latency = 0;
		got = '0;
		start = 1'b1;
		oper = bf16_pkg::OP_DIV;
		a = 16'h4100;
		b = 16'h4000;
		for (int i = 0; i < 30; i++)
		begin
			next_cycle();
			if (data_valid)
			begin
				pulses++;
				latency = i + 1;
				got = data;
			end
			else
				compare_word("data", data, '0);
			if (i < 3)
			begin
				// multiply while the divider is busy
				start = 1'b1;
				oper = bf16_pkg::OP_MUL;
				a = 16'h3FC0;
				b = 16'h3FC0;
			end
			else
			begin
				start = (i == 3);
				oper = 3'd6;
			end
		end
		compare_count("data_valid pulses", pulses, 1);
		compare_count("div latency", latency, DIV_STEPS + 2);
		compare_word("data", got, quotient_model(16'h4100, 16'h4000));
		// reserved code while idle
		pulses = 0;
		start = 1'b1;
		oper = 3'd6;
		for (int i = 0; i < 20; i++)
		begin
			next_cycle();
			if (data_valid)
				pulses++;
			compare_word("data", data, '0);
			compare_flag("can_accept_cmd", can_accept_cmd, 1'b1);
			start = (i < 2);
		end
		compare_count("data_valid pulses", pulses, 0);
		end_test("ignored commands");
	endtask

	initial
	begin
		lcg_state = 32'h3895;
		n_checks = 0;
		n_errors = 0;
		rst = 1'b1;
		start = 1'b0;
		oper = bf16_pkg::OP_ADD;
		a = '0;
		b = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_tests();
		add_sub_tests();
		multiply_tests();
		divide_tests();
		compare_tests();
		ignored_cmd_tests();
		start = 1'b0;
		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/bf16_pkg.sv
verilog/bf16_slt.sv
verilog/bf16_add.sv
verilog/bf16_mul.sv
verilog/bf16_div.sv
verilog/bf16_fpu.sv
tb/tb_bf16_fpu.sv

// ==== Bender.yml ====
package:
  name: bf16_fpu

sources:
  - verilog/bf16_pkg.sv
  - verilog/bf16_slt.sv
  - verilog/bf16_add.sv
  - verilog/bf16_mul.sv
  - verilog/bf16_div.sv
  - verilog/bf16_fpu.sv
  - target: test
    files:
      - tb/tb_bf16_fpu.sv
